// File: common/cpuIsaPkg.sv
`include "cpu_defines.svh"

package cpuIsaPkg;

	// Low nibble of every ALU opcode is its aluOp_e value
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_ADD  = 8'h10, OP_SUB  = 8'h11, OP_MUL  = 8'h12, OP_XOR  = 8'h13, OP_OR   = 8'h14,
		OP_AND  = 8'h15, OP_SLL  = 8'h16, OP_SRA  = 8'h17, OP_SRL  = 8'h18, OP_SLE  = 8'h19,
		OP_ADDI = 8'h20, OP_SUBI = 8'h21, OP_MULI = 8'h22, OP_XORI = 8'h23, OP_ORI  = 8'h24,
		OP_ANDI = 8'h25, OP_SLLI = 8'h26, OP_SRAI = 8'h27, OP_SRLI = 8'h28, OP_SLEI = 8'h29,
		OP_LB   = 8'h30, OP_LBU  = 8'h31, OP_LH   = 8'h32, OP_LHU  = 8'h33, OP_LW   = 8'h34,
		OP_SB   = 8'h40, OP_SH   = 8'h41, OP_SW   = 8'h42,
		OP_BEQ  = 8'h50, OP_BNE  = 8'h51,
		OP_J    = 8'h60
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_MUL = 4'd2,
		ALU_XOR = 4'd3,
		ALU_OR  = 4'd4,
		ALU_AND = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_SRL = 4'd8,
		ALU_SLE = 4'd9 // Signed a <= b gives 1
	} aluOp_e;

	typedef enum logic [1:0] {
		ALU_SRC_REG   = 2'd0,
		ALU_SRC_IMM   = 2'd1,
		ALU_SRC_SHAMT = 2'd2
	} aluSrc_e;

	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wbSel_e;

	typedef struct packed {
		logic [`CPU_REG_IDX_W-1:0] rd;
		logic [`CPU_REG_IDX_W-1:0] ra;
		logic [`CPU_REG_IDX_W-1:0] rb;
		logic [8:0] unused;
		opcode_e opcode;
	} rType_t;

	// Shift immediates take their amount from imm14[4:0]
	typedef struct packed {
		logic [`CPU_REG_IDX_W-1:0] rd;
		logic [`CPU_REG_IDX_W-1:0] ra;
		logic [13:0] imm14;
		opcode_e opcode;
	} iType_t;

	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_u;

endpackage

// File: common/cpuMemPkg.sv
`include "cpu_defines.svh"

package cpuMemPkg;

	// Access width on the data port
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} memSize_e;

	typedef logic [`CPU_WORD_W/8-1:0] byteEn_t; // One bit per byte lane

endpackage

// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Core widths, fixed by the instruction format
`define CPU_WORD_W 32
`define CPU_PC_W 12 // Byte address on both ports

`define CPU_REG_COUNT 32
`define CPU_REG_IDX_W 5

`endif

// File: pipeCpu.f
+incdir+common
common/cpuIsaPkg.sv
common/cpuMemPkg.sv
verilog/regFile.sv
verilog/hazardUnit.sv
pipeline/fetchUnit.sv
pipeline/instrDecoder.sv
pipeline/executeStage.sv
pipeline/memAccess.sv
verilog/pipeCpu.sv
verif/pipeCpu_asserts.sv
verif/tb_pipeCpu.sv

// File: pipeline/executeStage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeStage (
	input logic clk,
	input logic reset,
	input cpuIsaPkg::aluOp_e aluOp,
	input cpuIsaPkg::aluSrc_e aluSrc,
	input logic regWrite, memRead, memWrite,
	input cpuMemPkg::memSize_e memSize,
	input logic loadSigned,
	input cpuIsaPkg::wbSel_e wbSel,
	input logic branchEq, branchNe,
	input logic [`CPU_REG_IDX_W-1:0] srcA, srcB, destReg,
	input logic [`CPU_WORD_W-1:0] immExt,
	input logic [4:0] shamt,
	input logic [`CPU_PC_W-1:0] idPcNext,
	input logic [`CPU_WORD_W-1:0] readDataA, readDataB,
	input logic [1:0] fwdA, fwdB,
	input logic [`CPU_WORD_W-1:0] memAluResult, wbWriteData,
	input logic loadStall, memFreeze, flushIdEx,
	output logic [`CPU_REG_IDX_W-1:0] exSrcA, exSrcB, exDest,
	output logic exRegWrite, exMemRead, exMemWrite,
	output cpuMemPkg::memSize_e exMemSize,
	output logic exLoadSigned,
	output cpuIsaPkg::wbSel_e exWbSel,
	output logic [`CPU_WORD_W-1:0] aluResult, storeData,
	output logic branchTaken,
	output logic [`CPU_PC_W-1:0] branchTarget
);
	import cpuIsaPkg::*;

	aluOp_e exAluOp;
	aluSrc_e exAluSrc;
	logic exBranchEq, exBranchNe;
	logic [`CPU_WORD_W-1:0] exDataA, exDataB, exImm;
	logic [4:0] exShamt;
	logic [`CPU_PC_W-1:0] exPcNext;
	logic [`CPU_WORD_W-1:0] opA, opB;
	logic bubble;
	logic zero;

	function automatic logic [`CPU_WORD_W-1:0] fwdMux(
		input logic [1:0] sel,
		input logic [`CPU_WORD_W-1:0] regVal, memVal, wbVal
	);
		case (sel)
			2'b10: return memVal;
			2'b01: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign bubble = loadStall || flushIdEx;

	// ID/EX control, cleared to a bubble on stall or flush
	always_ff @(posedge clk) begin
		if (reset) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranchEq <= 1'b0;
			exBranchNe <= 1'b0;
		end else if (!memFreeze) begin
			exRegWrite <= regWrite && !bubble;
			exMemRead <= memRead && !bubble;
			exMemWrite <= memWrite && !bubble;
			exBranchEq <= branchEq && !bubble;
			exBranchNe <= branchNe && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!memFreeze) begin
			exAluOp <= aluOp;
			exAluSrc <= aluSrc;
			exMemSize <= memSize;
			exLoadSigned <= loadSigned;
			exWbSel <= wbSel;
			exSrcA <= srcA;
			exSrcB <= srcB;
			exDest <= destReg;
			exDataA <= readDataA;
			exDataB <= readDataB;
			exImm <= immExt;
			exShamt <= shamt;
			exPcNext <= idPcNext;
		end
	end

	assign opA = fwdMux(fwdA, exDataA, memAluResult, wbWriteData);
	assign storeData = fwdMux(fwdB, exDataB, memAluResult, wbWriteData);

	always_comb begin
		case (exAluSrc)
			ALU_SRC_IMM: opB = exImm;
			ALU_SRC_SHAMT: opB = {{(`CPU_WORD_W-5){1'b0}}, exShamt};
			default: opB = storeData;
		endcase
	end

	always_comb begin
		case (exAluOp)
			ALU_SUB: aluResult = opA - opB;
			ALU_MUL: aluResult = opA * opB; // Low word only
			ALU_XOR: aluResult = opA ^ opB;
			ALU_OR: aluResult = opA | opB;
			ALU_AND: aluResult = opA & opB;
			ALU_SLL: aluResult = opA << opB[4:0];
			ALU_SRA: aluResult = $signed(opA) >>> opB[4:0];
			ALU_SRL: aluResult = opA >> opB[4:0];
			ALU_SLE: aluResult = {{(`CPU_WORD_W-1){1'b0}}, $signed(opA) <= $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	assign zero = (aluResult == '0);
	assign branchTarget = exImm[`CPU_PC_W-1:0];

	// A branch to its own fall-through needs no redirect
	assign branchTaken = ((exBranchEq && zero) || (exBranchNe && !zero))
		&& branchTarget != exPcNext;

endmodule

// File: pipeline/fetchUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchUnit (
	input logic clk,
	input logic reset,
	input logic [`CPU_WORD_W-1:0] instrData,
	input logic instrReady,
	input logic loadStall,
	input logic memFreeze,
	input logic flushIfId,
	input logic jumpTaken,
	input logic [`CPU_PC_W-1:0] jumpTarget,
	input logic branchTaken,
	input logic [`CPU_PC_W-1:0] branchTarget,
	output logic [`CPU_PC_W-1:0] instrAddr,
	output logic instrRequest,
	output cpuIsaPkg::instr_u ifIdInstr,
	output logic [`CPU_PC_W-1:0] ifIdPcNext
);
	logic [`CPU_PC_W-1:0] pc;
	logic [`CPU_PC_W-1:0] pcPlus4;
	logic [`CPU_PC_W-1:0] pcNext;
	logic advance;

	assign pcPlus4 = pc + 'd4;
	assign pcNext = branchTaken ? branchTarget : (jumpTaken ? jumpTarget : pcPlus4);

	// Load-use stall holds PC and IF/ID
	assign advance = instrReady && !memFreeze && !loadStall;

	assign instrAddr = pc; // Held steady until the fetch completes
	assign instrRequest = 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifIdInstr <= '0; // Opcode 0 is a no-op
		end else if (advance) begin
			pc <= pcNext;
			ifIdInstr <= flushIfId ? '0 : instrData;
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			ifIdPcNext <= pcPlus4;
	end

endmodule

// File: pipeline/instrDecoder.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instrDecoder (
	input cpuIsaPkg::instr_u ifIdInstr,
	output cpuIsaPkg::aluOp_e aluOp,
	output cpuIsaPkg::aluSrc_e aluSrc,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output cpuMemPkg::memSize_e memSize,
	output logic loadSigned,
	output cpuIsaPkg::wbSel_e wbSel,
	output logic branchEq,
	output logic branchNe,
	output logic jumpTaken,
	output logic [`CPU_PC_W-1:0] jumpTarget,
	output logic [`CPU_REG_IDX_W-1:0] srcA,
	output logic [`CPU_REG_IDX_W-1:0] srcB,
	output logic [`CPU_REG_IDX_W-1:0] destReg,
	output logic [`CPU_WORD_W-1:0] immExt,
	output logic [4:0] shamt
);
	import cpuIsaPkg::*;
	import cpuMemPkg::*;

	logic useRdSlot; // Stores and branches read rd as a source

	assign srcA = ifIdInstr.r.ra;
	assign srcB = useRdSlot ? ifIdInstr.r.rd : ifIdInstr.r.rb;
	assign destReg = ifIdInstr.r.rd;
	assign immExt = {{(`CPU_WORD_W-14){ifIdInstr.i.imm14[13]}}, ifIdInstr.i.imm14};
	assign shamt = ifIdInstr.i.imm14[4:0];
	assign jumpTarget = ifIdInstr.i.imm14[`CPU_PC_W-1:0]; // Absolute

	always_comb begin
		aluOp = ALU_ADD;
		aluSrc = ALU_SRC_REG;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = MEM_WORD;
		loadSigned = 1'b0;
		wbSel = WB_ALU;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jumpTaken = 1'b0;
		useRdSlot = 1'b0;
		case (ifIdInstr.r.opcode)
			OP_ADD, OP_SUB, OP_MUL, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRA, OP_SRL, OP_SLE: begin
				aluOp = aluOp_e'(ifIdInstr[3:0]);
				regWrite = 1'b1;
			end
			OP_ADDI, OP_SUBI, OP_MULI, OP_XORI, OP_ORI, OP_ANDI, OP_SLEI: begin
				aluOp = aluOp_e'(ifIdInstr[3:0]);
				aluSrc = ALU_SRC_IMM;
				regWrite = 1'b1;
			end
			OP_SLLI, OP_SRAI, OP_SRLI: begin
				aluOp = aluOp_e'(ifIdInstr[3:0]);
				aluSrc = ALU_SRC_SHAMT;
				regWrite = 1'b1;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				aluSrc = ALU_SRC_IMM; // Address is ra + imm
				regWrite = 1'b1;
				memRead = 1'b1;
				wbSel = WB_MEM;
				loadSigned = (ifIdInstr.r.opcode inside {OP_LB, OP_LH});
				if (ifIdInstr.r.opcode inside {OP_LB, OP_LBU})
					memSize = MEM_BYTE;
				else if (ifIdInstr.r.opcode inside {OP_LH, OP_LHU})
					memSize = MEM_HALF;
			end
			OP_SB, OP_SH, OP_SW: begin
				aluSrc = ALU_SRC_IMM;
				memWrite = 1'b1;
				useRdSlot = 1'b1;
				if (ifIdInstr.r.opcode == OP_SB)
					memSize = MEM_BYTE;
				else if (ifIdInstr.r.opcode == OP_SH)
					memSize = MEM_HALF;
			end
			OP_BEQ, OP_BNE: begin
				aluOp = ALU_SUB; // Zero flag decides
				useRdSlot = 1'b1;
				branchEq = (ifIdInstr.r.opcode == OP_BEQ);
				branchNe = (ifIdInstr.r.opcode == OP_BNE);
			end
			OP_J: jumpTaken = 1'b1;
			default: ; // Unknown opcodes fall through as no-ops
		endcase
	end

endmodule

// File: pipeline/memAccess.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memAccess (
	input logic clk,
	input logic reset,
	input logic memFreeze,
	input logic [`CPU_REG_IDX_W-1:0] exDest,
	input logic exRegWrite, exMemRead, exMemWrite,
	input cpuMemPkg::memSize_e exMemSize,
	input logic exLoadSigned,
	input cpuIsaPkg::wbSel_e exWbSel,
	input logic [`CPU_WORD_W-1:0] aluResult, storeData,
	input logic [`CPU_WORD_W-1:0] dataReadData,
	input logic dataReady,
	output logic [`CPU_PC_W-1:0] dataAddr,
	output logic dataRequest,
	output logic dataWrite,
	output logic [`CPU_WORD_W-1:0] dataWriteData,
	output cpuMemPkg::byteEn_t dataByteEn,
	output logic [`CPU_WORD_W-1:0] memAluResult,
	output logic [`CPU_REG_IDX_W-1:0] memDest,
	output logic memRegWrite,
	output logic [`CPU_REG_IDX_W-1:0] wbDest,
	output logic wbRegWrite,
	output logic [`CPU_WORD_W-1:0] wbWriteData
);
	import cpuIsaPkg::*;
	import cpuMemPkg::*;

	memSize_e memSize;
	logic memSigned;
	wbSel_e memWbSel;
	logic [1:0] offset;
	byteEn_t byteEnNext;
	logic [`CPU_WORD_W-1:0] laneData;
	logic [`CPU_WORD_W-1:0] loadData;
	logic memAdvance;

	assign offset = aluResult[1:0];

	always_comb begin
		case (exMemSize)
			MEM_BYTE: byteEnNext = byteEn_t'(4'b0001 << offset);
			MEM_HALF: byteEnNext = byteEn_t'(4'b0011 << offset);
			default: byteEnNext = '1;
		endcase
	end

	// EX/MEM drives the data port directly
	always_ff @(posedge clk) begin
		if (reset) begin
			dataRequest <= 1'b0;
			dataWrite <= 1'b0;
			memRegWrite <= 1'b0;
		end else if (!memFreeze) begin
			dataRequest <= exMemRead || exMemWrite;
			dataWrite <= exMemWrite;
			memRegWrite <= exRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!memFreeze) begin
			dataAddr <= aluResult[`CPU_PC_W-1:0];
			dataWriteData <= storeData << {offset, 3'b000}; // Into its byte lane
			dataByteEn <= byteEnNext;
			memAluResult <= aluResult;
			memDest <= exDest;
			memSize <= exMemSize;
			memSigned <= exLoadSigned;
			memWbSel <= exWbSel;
		end
	end

	assign laneData = dataReadData >> {dataAddr[1:0], 3'b000};

	always_comb begin
		case (memSize)
			MEM_BYTE: loadData = {{(`CPU_WORD_W-8){memSigned && laneData[7]}}, laneData[7:0]};
			MEM_HALF: loadData = {{(`CPU_WORD_W-16){memSigned && laneData[15]}}, laneData[15:0]};
			default: loadData = laneData;
		endcase
	end

	// MEM/WB moves once the data handshake is done
	assign memAdvance = !memFreeze && (!dataRequest || dataReady);

	always_ff @(posedge clk) begin
		if (reset)
			wbRegWrite <= 1'b0;
		else if (memAdvance)
			wbRegWrite <= memRegWrite;
	end

	always_ff @(posedge clk) begin
		if (memAdvance) begin
			wbDest <= memDest;
			wbWriteData <= (memWbSel == WB_MEM) ? loadData : memAluResult;
		end
	end

endmodule

// File: verif/pipeCpu_asserts.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pipeCpu_asserts (
	input logic clk,
	input logic reset,
	input logic [`CPU_PC_W-1:0] instrAddr,
	input logic instrRequest,
	input logic instrReady,
	input logic [`CPU_PC_W-1:0] dataAddr,
	input logic dataRequest,
	input logic dataWrite,
	input logic [`CPU_WORD_W-1:0] dataWriteData,
	input cpuMemPkg::byteEn_t dataByteEn,
	input logic dataReady,
	input logic wbRegWrite
);
	int failCount = 0; // Count of failed port checks

	// Checked from the second reset cycle, once the registers have cleared
	noDataRequestInReset: assert property (@(posedge clk)
		reset && $past(reset) |-> !dataRequest)
		else begin
			failCount++;
			$error("Data request raised during reset");
		end

	noRegWriteInReset: assert property (@(posedge clk)
		reset && $past(reset) |-> !wbRegWrite)
		else begin
			failCount++;
			$error("Register write during reset");
		end

	instrHold: assert property (@(posedge clk) disable iff (reset)
		instrRequest && !instrReady |=> instrRequest && $stable(instrAddr))
		else begin
			failCount++;
			$error("Instruction request or address changed while waiting for ready");
		end

	dataHold: assert property (@(posedge clk) disable iff (reset)
		dataRequest && !dataReady |=> dataRequest && $stable(dataAddr)
			&& $stable(dataWrite) && $stable(dataWriteData) && $stable(dataByteEn))
		else begin
			failCount++;
			$error("Data request outputs changed while waiting for ready");
		end

endmodule

bind pipeCpu pipeCpu_asserts portChecks (.*);

// File: verif/tb_pipeCpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_pipeCpu;
	import cpuIsaPkg::*;
	import cpuMemPkg::*;

	localparam int progLen = 70;
	localparam int storeCount = 31;
	localparam int timeoutCycles = progLen * 10 + 100;

	logic clk;
	logic reset;
	logic [`CPU_PC_W-1:0] instrAddr;
	logic instrRequest;
	logic [`CPU_WORD_W-1:0] instrData;
	logic instrReady;
	logic [`CPU_PC_W-1:0] dataAddr;
	logic dataRequest;
	logic dataWrite;
	logic [`CPU_WORD_W-1:0] dataWriteData;
	byteEn_t dataByteEn;
	logic [`CPU_WORD_W-1:0] dataReadData;
	logic dataReady;

	logic [`CPU_WORD_W-1:0] imem [1024];
	logic [7:0] dmem [4096];
	logic [31:0] lcgState;
	int instrWait;
	int dataWait;
	int storeIdx;
	logic storeDone;
	logic storeOk;

	// Hand-computed store stream: address, byte enables, data under the enables
	logic [`CPU_PC_W-1:0] expAddr [storeCount] = '{
		'h400, 'h404, 'h408, 'h40C, 'h410, 'h414, 'h418, 'h41C, 'h420, 'h424, 'h428,
		'h42C, 'h430, 'h434, 'h438, 'h43C, 'h440, 'h444, 'h448, 'h44C,
		'h450, 'h454, 'h458, 'h45C, 'h460, 'h464, 'h471, 'h476, 'h473, 'h468, 'h46C
	};
	logic [3:0] expBe [storeCount] = '{
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h2, 4'hC, 4'h8, 4'hF, 4'hF
	};
	logic [31:0] expData [storeCount] = '{
		32'h0000005D, 32'h0000006B, 32'hFFFFFD13, 32'hFFFFFF9D, 32'hFFFFFFFD,
		32'h00000060, 32'hFFFFFFC8, 32'hFFFFFFFF, 32'h1FFFFFFF, 32'h00000001,
		32'h00000000, 32'h00000046, 32'hFFFFFF2E, 32'h00000094, 32'h00000067,
		32'h00000024, 32'h00000640, 32'hFFFFFFFC, 32'h0000000F, 32'h00000000,
		32'hFFFFFFA3, 32'h000000F2, 32'hFFFF8081, 32'h0000F2A3, 32'h8081F2A3,
		32'h8081F307, 32'h00006400, 32'hFFF90000, 32'hF9000000, 32'h0000006B,
		32'hFFFFFD13
	};

	pipeCpu dut (.*);

	always #50 clk = ~clk;

	function automatic instr_u encodeR(opcode_e op, int rd, int ra, int rb);
		instr_u w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd[4:0];
		w.r.ra = ra[4:0];
		w.r.rb = rb[4:0];
		return w;
	endfunction

	function automatic instr_u encodeI(opcode_e op, int rd, int ra, int imm);
		instr_u w;
		w = '0;
		w.i.opcode = op;
		w.i.rd = rd[4:0];
		w.i.ra = ra[4:0];
		w.i.imm14 = imm[13:0];
		return w;
	endfunction

	// LCG step, wait of 0 to 3 cycles
	function int randDelay();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[17:16]);
	endfunction

	function automatic logic [31:0] byteMask(logic [3:0] be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	// Behavior that each expected store belongs to
	function automatic string storeTestName(int idx);
		if (idx < 20)
			return "alu";
		if (idx < 25)
			return "loads";
		if (idx == 25)
			return "load-use";
		if (idx < 29)
			return "store byte enables";
		return "control flow";
	endfunction

	task automatic loadProgram();
		for (int a = 0; a < 1024; a++)
			imem[a] = '0;
		imem[0] = encodeI(OP_ADDI, 1, 0, 100);
		imem[1] = encodeI(OP_ADDI, 2, 0, -7);
		imem[2] = encodeR(OP_ADD, 3, 1, 2); // Both forwarding paths
		imem[3] = encodeI(OP_SW, 3, 0, 'h400);
		imem[4] = encodeR(OP_SUB, 4, 1, 2);
		imem[5] = encodeR(OP_MUL, 5, 4, 2);
		imem[6] = encodeI(OP_SW, 4, 0, 'h404);
		imem[7] = encodeI(OP_SW, 5, 0, 'h408);
		imem[8] = encodeR(OP_XOR, 6, 1, 2);
		imem[9] = encodeR(OP_OR, 7, 1, 2);
		imem[10] = encodeR(OP_AND, 8, 1, 2);
		for (int k = 0; k < 3; k++)
			imem[11 + k] = encodeI(OP_SW, 6 + k, 0, 'h40C + 4 * k);
		imem[14] = encodeI(OP_ADDI, 9, 0, 3);
		imem[15] = encodeR(OP_SLL, 10, 2, 9);
		imem[16] = encodeR(OP_SRA, 11, 2, 9);
		imem[17] = encodeR(OP_SRL, 12, 2, 9);
		imem[18] = encodeR(OP_SLE, 13, 2, 1);
		imem[19] = encodeR(OP_SLE, 14, 1, 2);
		for (int k = 0; k < 5; k++)
			imem[20 + k] = encodeI(OP_SW, 10 + k, 0, 'h418 + 4 * k);
		imem[25] = encodeI(OP_SUBI, 15, 1, 30);
		imem[26] = encodeI(OP_MULI, 16, 15, -3);
		imem[27] = encodeI(OP_XORI, 17, 1, 'hF0);
		imem[28] = encodeI(OP_ORI, 18, 1, 3);
		imem[29] = encodeI(OP_ANDI, 19, 1, 'h2C);
		imem[30] = encodeI(OP_SLLI, 20, 1, 4);
		imem[31] = encodeI(OP_SRAI, 21, 2, 1);
		imem[32] = encodeI(OP_SRLI, 22, 2, 28);
		imem[33] = encodeI(OP_SLEI, 23, 1, 99);
		for (int k = 0; k < 9; k++)
			imem[34 + k] = encodeI(OP_SW, 15 + k, 0, 'h42C + 4 * k);
		imem[43] = encodeI(OP_LB, 24, 0, 'h300);
		imem[44] = encodeI(OP_LBU, 25, 0, 'h301);
		imem[45] = encodeI(OP_LH, 26, 0, 'h302);
		imem[46] = encodeI(OP_LHU, 27, 0, 'h300);
		imem[47] = encodeI(OP_LW, 28, 0, 'h300);
		for (int k = 0; k < 5; k++)
			imem[48 + k] = encodeI(OP_SW, 24 + k, 0, 'h450 + 4 * k);
		imem[53] = encodeI(OP_LW, 29, 0, 'h300);
		imem[54] = encodeR(OP_ADD, 30, 29, 1); // Load-use stall
		imem[55] = encodeI(OP_SW, 30, 0, 'h464);
		imem[56] = encodeI(OP_SB, 1, 0, 'h471);
		imem[57] = encodeI(OP_SH, 2, 0, 'h476);
		imem[58] = encodeI(OP_SB, 2, 0, 'h473);
		imem[59] = encodeI(OP_BEQ, 1, 1, 63 * 4); // Taken
		for (int k = 0; k < 3; k++)
			imem[60 + k] = encodeI(OP_SW, 3, 0, 'h4F0);
		imem[63] = encodeI(OP_BNE, 1, 1, 'h200); // Not taken
		imem[64] = encodeI(OP_SW, 4, 0, 'h468);
		imem[65] = encodeI(OP_J, 0, 0, 68 * 4);
		imem[66] = encodeI(OP_SW, 3, 0, 'h4F0);
		imem[67] = encodeI(OP_SW, 3, 0, 'h4F0);
		imem[68] = encodeI(OP_SW, 5, 0, 'h46C);
		imem[69] = encodeI(OP_J, 0, 0, 69 * 4); // Park here
	endtask

	task automatic reportStoreError();
		if (storeIdx >= storeCount) begin
			$display("Unexpected extra store to address %h after the last expected store",
				dataAddr);
		end else begin
			$display("CHECK FAILED %s store %0d: expected addr %h be %b data %h,",
				storeTestName(storeIdx), storeIdx, expAddr[storeIdx],
				expBe[storeIdx], expData[storeIdx],
				" actual addr %h be %b data %h",
				dataAddr, dataByteEn, dataWriteData & byteMask(dataByteEn));
		end
		$display("Result: FAILED");
		$fatal(1, "Store mismatch");
	endtask

	// A store completes only when the instruction port does not freeze the core
	assign storeDone = dataRequest && dataWrite && dataReady && instrReady;

	always_comb begin
		storeOk = storeIdx < storeCount
			&& dataAddr == expAddr[storeIdx]
			&& dataByteEn == expBe[storeIdx]
			&& (dataWriteData & byteMask(dataByteEn)) == expData[storeIdx];
	end

	storeCheck: assert property (@(negedge clk) disable iff (reset) storeDone |-> storeOk)
		else reportStoreError();

	always @(negedge clk) begin
		if (!reset && storeDone && storeOk) begin
			for (int b = 0; b < 4; b++)
				if (dataByteEn[b])
					dmem[{dataAddr[11:2], 2'(b)}] <= dataWriteData[8*b +: 8];
			storeIdx <= storeIdx + 1;
		end
	end

	// Bound port checks count their failures
	always @(negedge clk) begin
		if (dut.portChecks.failCount != 0) begin
			$display("A port handshake assertion failed");
			$display("Result: FAILED");
			$fatal(1, "Port check failed");
		end
	end

	// Port models, driven just after the edge
	always @(posedge clk) begin
		#5;
		if (reset) begin
			instrReady = 1'b0;
			dataReady = 1'b0;
		end else begin
			if (instrWait == 0) begin
				instrReady = 1'b1;
				instrWait = randDelay();
			end else begin
				instrReady = 1'b0;
				instrWait = instrWait - 1;
			end
			if (dataWait == 0) begin
				dataReady = 1'b1;
				dataWait = randDelay();
			end else begin
				dataReady = 1'b0;
				dataWait = dataWait - 1;
			end
		end
		instrData = imem[instrAddr[11:2]];
		dataReadData = {dmem[{dataAddr[11:2], 2'd3}], dmem[{dataAddr[11:2], 2'd2}],
			dmem[{dataAddr[11:2], 2'd1}], dmem[{dataAddr[11:2], 2'd0}]};
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instrData = '0;
		instrReady = 1'b0;
		dataReadData = '0;
		dataReady = 1'b0;
		lcgState = 32'ha97f;
		instrWait = 0;
		dataWait = 0;
		storeIdx = 0;
		loadProgram();
		for (int a = 0; a < 4096; a++)
			dmem[a] = 8'(a ^ (a >> 8));
		dmem['h300] = 8'hA3; // Word 8081F2A3 for the loads
		dmem['h301] = 8'hF2;
		dmem['h302] = 8'h81;
		dmem['h303] = 8'h80;
		repeat (8) @(posedge clk);
		#5 reset = 1'b0;
		while (storeIdx < storeCount)
			@(posedge clk);
		repeat (20) @(posedge clk); // Room for a stray store to show up
		#10; // Let the last edge's checks finish
		if (dut.portChecks.failCount == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("A port handshake assertion failed");
			$display("Result: FAILED");
			$fatal(1, "Port check failed");
		end
	end

	initial begin
		repeat (timeoutCycles + 8) @(posedge clk);
		$display("Timeout: the program did not complete all of its stores in time");
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module hazardUnit (
	input logic [`CPU_REG_IDX_W-1:0] idSrcA,
	input logic [`CPU_REG_IDX_W-1:0] idSrcB,
	input logic exMemRead,
	input logic [`CPU_REG_IDX_W-1:0] exDest,
	input logic exRegWrite,
	input logic [`CPU_REG_IDX_W-1:0] memDest,
	input logic memRegWrite,
	input logic [`CPU_REG_IDX_W-1:0] wbDest,
	input logic wbRegWrite,
	input logic [`CPU_REG_IDX_W-1:0] exSrcA,
	input logic [`CPU_REG_IDX_W-1:0] exSrcB,
	input logic instrRequest, instrReady,
	input logic dataRequest, dataReady,
	input logic branchTaken, jumpTaken,
	output logic loadStall, memFreeze,
	output logic flushIfId, flushIdEx,
	output logic [1:0] fwdA, fwdB
);
	// 10 picks EX/MEM, 01 picks MEM/WB, 00 keeps the register value
	function automatic logic [1:0] fwdSel(
		input logic [`CPU_REG_IDX_W-1:0] src,
		input logic mWrite,
		input logic [`CPU_REG_IDX_W-1:0] mDest,
		input logic wWrite,
		input logic [`CPU_REG_IDX_W-1:0] wDest
	);
		if (mWrite && mDest != '0 && mDest == src)
			return 2'b10;
		if (wWrite && wDest != '0 && wDest == src)
			return 2'b01;
		return 2'b00;
	endfunction

	assign fwdA = fwdSel(exSrcA, memRegWrite, memDest, wbRegWrite, wbDest);
	assign fwdB = fwdSel(exSrcB, memRegWrite, memDest, wbRegWrite, wbDest);

	// Load result not ready until MEM/WB
	assign loadStall = exMemRead && exRegWrite && exDest != '0
		&& (exDest == idSrcA || exDest == idSrcB);

	assign memFreeze = (instrRequest && !instrReady) || (dataRequest && !dataReady);
	assign flushIfId = branchTaken || jumpTaken;
	assign flushIdEx = branchTaken; // Jumps leave ID/EX alone

endmodule

// File: verilog/pipeCpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pipeCpu (
	input logic clk,
	input logic reset,
	output logic [`CPU_PC_W-1:0] instrAddr,
	output logic instrRequest,
	input logic [`CPU_WORD_W-1:0] instrData,
	input logic instrReady,
	output logic [`CPU_PC_W-1:0] dataAddr,
	output logic dataRequest,
	output logic dataWrite,
	output logic [`CPU_WORD_W-1:0] dataWriteData,
	output cpuMemPkg::byteEn_t dataByteEn,
	input logic [`CPU_WORD_W-1:0] dataReadData,
	input logic dataReady
);
	import cpuIsaPkg::*;
	import cpuMemPkg::*;

	// IF/ID and decode
	instr_u ifIdInstr;
	logic [`CPU_PC_W-1:0] ifIdPcNext;
	aluOp_e aluOp;
	aluSrc_e aluSrc;
	logic regWrite, memRead, memWrite;
	memSize_e memSize;
	logic loadSigned;
	wbSel_e wbSel;
	logic branchEq, branchNe, jumpTaken;
	logic [`CPU_PC_W-1:0] jumpTarget;
	logic [`CPU_REG_IDX_W-1:0] srcA, srcB, destReg;
	logic [`CPU_WORD_W-1:0] immExt;
	logic [4:0] shamt;
	logic [`CPU_WORD_W-1:0] readDataA, readDataB;

	// Hazard control
	logic loadStall, memFreeze, flushIfId, flushIdEx;
	logic [1:0] fwdA, fwdB;

	// Execute
	logic [`CPU_REG_IDX_W-1:0] exSrcA, exSrcB, exDest;
	logic exRegWrite, exMemRead, exMemWrite;
	memSize_e exMemSize;
	logic exLoadSigned;
	wbSel_e exWbSel;
	logic [`CPU_WORD_W-1:0] aluResult, storeData;
	logic branchTaken;
	logic [`CPU_PC_W-1:0] branchTarget;

	// Memory and writeback
	logic [`CPU_WORD_W-1:0] memAluResult, wbWriteData;
	logic [`CPU_REG_IDX_W-1:0] memDest, wbDest;
	logic memRegWrite, wbRegWrite;

	fetchUnit fetch (
		.clk, .reset, .instrData, .instrReady, .loadStall, .memFreeze, .flushIfId,
		.jumpTaken, .jumpTarget, .branchTaken, .branchTarget,
		.instrAddr, .instrRequest, .ifIdInstr, .ifIdPcNext
	);

	instrDecoder decode (
		.ifIdInstr, .aluOp, .aluSrc, .regWrite, .memRead, .memWrite, .memSize,
		.loadSigned, .wbSel, .branchEq, .branchNe, .jumpTaken, .jumpTarget,
		.srcA, .srcB, .destReg, .immExt, .shamt
	);

	regFile regs (
		.clk, .reset,
		.readAddrA(srcA), .readAddrB(srcB),
		.writeEn(wbRegWrite), .writeAddr(wbDest), .writeData(wbWriteData),
		.readDataA, .readDataB
	);

	hazardUnit hazards (
		.idSrcA(srcA), .idSrcB(srcB), .exMemRead, .exDest, .exRegWrite,
		.memDest, .memRegWrite, .wbDest, .wbRegWrite, .exSrcA, .exSrcB,
		.instrRequest, .instrReady, .dataRequest, .dataReady, .branchTaken, .jumpTaken,
		.loadStall, .memFreeze, .flushIfId, .flushIdEx, .fwdA, .fwdB
	);

	executeStage execute (
		.clk, .reset, .aluOp, .aluSrc, .regWrite, .memRead, .memWrite, .memSize,
		.loadSigned, .wbSel, .branchEq, .branchNe, .srcA, .srcB, .destReg, .immExt,
		.shamt, .idPcNext(ifIdPcNext), .readDataA, .readDataB, .fwdA, .fwdB,
		.memAluResult, .wbWriteData, .loadStall, .memFreeze, .flushIdEx,
		.exSrcA, .exSrcB, .exDest, .exRegWrite, .exMemRead, .exMemWrite, .exMemSize,
		.exLoadSigned, .exWbSel, .aluResult, .storeData, .branchTaken, .branchTarget
	);

	memAccess memStage (
		.clk, .reset, .memFreeze, .exDest, .exRegWrite, .exMemRead, .exMemWrite,
		.exMemSize, .exLoadSigned, .exWbSel, .aluResult, .storeData,
		.dataReadData, .dataReady, .dataAddr, .dataRequest, .dataWrite, .dataWriteData,
		.dataByteEn, .memAluResult, .memDest, .memRegWrite, .wbDest, .wbRegWrite,
		.wbWriteData
	);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
	input logic clk,
	input logic reset,
	input logic [`CPU_REG_IDX_W-1:0] readAddrA,
	input logic [`CPU_REG_IDX_W-1:0] readAddrB,
	input logic writeEn,
	input logic [`CPU_REG_IDX_W-1:0] writeAddr,
	input logic [`CPU_WORD_W-1:0] writeData,
	output logic [`CPU_WORD_W-1:0] readDataA,
	output logic [`CPU_WORD_W-1:0] readDataB
);
	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];

	// r0 reads zero, a same-cycle write wins over the stored value
	function automatic logic [`CPU_WORD_W-1:0] readPort(input logic [`CPU_REG_IDX_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (writeEn && writeAddr == addr)
			return writeData;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!reset && writeEn && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	always_comb readDataA = readPort(readAddrA);
	always_comb readDataB = readPort(readAddrB);

endmodule
